// File: logic/mca_params.svh
`ifndef MCA_PARAMS_SVH
`define MCA_PARAMS_SVH

// adc sample width, also the width of a pulse height.
`define MCA_SAMPLE_WIDTH 16

// histogram bin index bits, 256 bins.
`define MCA_BIN_BITS 8

// bin count width, also used for the acquisition length.
`define MCA_COUNT_WIDTH 32

// dead-time counter width in valid samples.
`define MCA_DELAY_WIDTH 16

`endif

// File: logic/mca_data_pkg.sv
`default_nettype none

`include "mca_params.svh"

package mca_data_pkg;

  // one unsigned adc sample.
  typedef logic [`MCA_SAMPLE_WIDTH-1:0] sample_t;

  // peak minus minimum, and the lower and upper cuts.
  typedef logic [`MCA_SAMPLE_WIDTH-1:0] height_t;

  typedef logic [`MCA_DELAY_WIDTH-1:0]  delay_t;

  typedef logic [`MCA_BIN_BITS-1:0]     bin_addr_t;

  // bin count, and acquisition length in clock cycles.
  typedef logic [`MCA_COUNT_WIDTH-1:0]  count_t;

endpackage

`default_nettype wire

// File: logic/mca_ctrl_pkg.sv
`default_nettype none

package mca_ctrl_pkg;

  typedef enum logic [1:0] {
    timer_idle,
    timer_run,
    timer_done
  } timer_state_t;

  // read and write together form one read-modify-write of a bin.
  typedef enum logic [1:0] {
    hist_idle,
    hist_clear,
    hist_read,
    hist_write
  } hist_state_t;

endpackage

`default_nettype wire

// File: logic/pulse_height_analyzer.sv
`default_nettype none

`include "mca_params.svh"

module pulse_height_analyzer
(
  input  wire                    aclk,
  input  wire                    aresetn,

  input  mca_data_pkg::sample_t  sample_data,
  input  wire                    sample_valid,

  input  mca_data_pkg::delay_t   cfg_delay,
  input  mca_data_pkg::height_t  cfg_min_cut,
  input  mca_data_pkg::height_t  cfg_max_cut,

  input  wire                    height_ready,
  output mca_data_pkg::height_t  height_data,
  output logic                   height_valid
);

  mca_data_pkg::sample_t smp0_q, smp0_d;
  mca_data_pkg::sample_t smp1_q, smp1_d;
  mca_data_pkg::sample_t min_q, min_d;
  mca_data_pkg::height_t height_q, height_d;
  mca_data_pkg::delay_t  cnt_q, cnt_d;
  logic                  armed_q, armed_d;
  logic                  rising_q, rising_d;
  logic                  valid_q, valid_d;

  mca_data_pkg::height_t diff;
  logic                  rising;
  logic                  above_min;
  logic                  below_max;
  logic                  in_delay;

  // rising is judged against the sample two back.
  assign rising    = smp1_q < sample_data;
  assign diff      = smp0_q - min_q;
  assign above_min = diff > cfg_min_cut;
  assign below_max = smp0_q < cfg_max_cut;
  assign in_delay  = cnt_q < cfg_delay;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      smp0_q   <= '0;
      smp1_q   <= '0;
      min_q    <= '0;
      height_q <= '0;
      cnt_q    <= {`MCA_DELAY_WIDTH{1'b0}};
      armed_q  <= 1'b0;
      rising_q <= 1'b0;
      valid_q  <= 1'b0;
    end
    else
    begin
      smp0_q   <= smp0_d;
      smp1_q   <= smp1_d;
      min_q    <= min_d;
      height_q <= height_d;
      cnt_q    <= cnt_d;
      armed_q  <= armed_d;
      rising_q <= rising_d;
      valid_q  <= valid_d;
    end
  end

  always_comb
  begin
    smp0_d   = smp0_q;
    smp1_d   = smp1_q;
    min_d    = min_q;
    height_d = height_q;
    cnt_d    = cnt_q;
    armed_d  = armed_q;
    rising_d = rising_q;
    valid_d  = valid_q;

    if (sample_valid)
    begin
      smp0_d   = sample_data;
      smp1_d   = smp0_q;
      rising_d = rising;
    end

    if (sample_valid && in_delay)
    begin
      cnt_d = cnt_q + 1'b1;
    end

    // a transfer frees the output, a new height below may refill it.
    if (height_valid && height_ready)
    begin
      valid_d = 1'b0;
    end

    // falling to rising after the dead time marks the minimum.
    if (sample_valid && !in_delay && !rising_q && rising)
    begin
      min_d   = smp1_q;
      armed_d = 1'b1;
    end

    // rising to falling while armed is the peak.
    if (sample_valid && armed_q && rising_q && !rising && above_min)
    begin
      armed_d = 1'b0;
      cnt_d   = {`MCA_DELAY_WIDTH{1'b0}};
      if (below_max)
      begin
        height_d = diff;
        valid_d  = 1'b1;
      end
    end
  end

  assign height_data  = height_q;
  assign height_valid = valid_q;

endmodule

`default_nettype wire

// File: logic/spectrum_histogram.sv
`default_nettype none

`include "mca_params.svh"

module spectrum_histogram
(
  input  wire                      aclk,
  input  wire                      aresetn,

  input  mca_data_pkg::height_t    height_data,
  input  wire                      height_valid,
  output logic                     height_ready,
  input  wire                      counting_window,

  input  wire                      clear_start,
  output logic                     clear_busy,

  input  mca_data_pkg::bin_addr_t  rd_addr,
  output mca_data_pkg::count_t     rd_data
);

  localparam int unsigned NUM_BINS = 1 << `MCA_BIN_BITS;

  mca_ctrl_pkg::hist_state_t state_q;

  mca_data_pkg::count_t      mem [0:NUM_BINS-1];
  mca_data_pkg::count_t      mem_q;
  mca_data_pkg::bin_addr_t   addr_q;
  mca_data_pkg::bin_addr_t   rd_sel;
  mca_data_pkg::bin_addr_t   bin;
  logic                      take;

  // bin index is the top bits of the height.
  assign bin = height_data[`MCA_SAMPLE_WIDTH-1 -: `MCA_BIN_BITS];

  // a clear request wins over a height offered in the same cycle.
  assign height_ready = (state_q == mca_ctrl_pkg::hist_idle) && !clear_start;
  assign take         = height_valid && height_ready;
  assign clear_busy   = (state_q == mca_ctrl_pkg::hist_clear);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state_q <= mca_ctrl_pkg::hist_idle;
      addr_q  <= '0;
    end
    else
    begin
      case (state_q)
        mca_ctrl_pkg::hist_idle:
        begin
          if (clear_start)
          begin
            addr_q  <= '0;
            state_q <= mca_ctrl_pkg::hist_clear;
          end
          else if (take && counting_window)
          begin
            addr_q  <= bin;
            state_q <= mca_ctrl_pkg::hist_read;
          end
        end
        mca_ctrl_pkg::hist_clear:
        begin
          addr_q <= addr_q + 1'b1;
          if (addr_q == {`MCA_BIN_BITS{1'b1}})
          begin
            state_q <= mca_ctrl_pkg::hist_idle;
          end
        end
        mca_ctrl_pkg::hist_read:
        begin
          state_q <= mca_ctrl_pkg::hist_write;
        end
        default:
        begin
          state_q <= mca_ctrl_pkg::hist_idle;
        end
      endcase
    end
  end

  // the single read port serves the bin update and the outside reader.
  assign rd_sel = (state_q == mca_ctrl_pkg::hist_read) ? addr_q : rd_addr;

  always_ff @(posedge aclk)
  begin
    mem_q <= mem[rd_sel];
    if (state_q == mca_ctrl_pkg::hist_clear)
    begin
      mem[addr_q] <= '0;
    end
    else if (state_q == mca_ctrl_pkg::hist_write)
    begin
      mem[addr_q] <= mem_q + mca_data_pkg::count_t'(1);
    end
  end

  assign rd_data = mem_q;

endmodule

`default_nettype wire

// File: logic/acquisition_timer.sv
`default_nettype none

`include "mca_params.svh"

module acquisition_timer
(
  input  wire                   aclk,
  input  wire                   aresetn,
  input  wire                   acq_start,
  input  mca_data_pkg::count_t  acq_time,
  output logic                  counting_window,
  output logic                  acq_busy,
  output logic                  acq_done
);

  mca_ctrl_pkg::timer_state_t state_q;
  mca_data_pkg::count_t       cnt_q;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state_q <= mca_ctrl_pkg::timer_idle;
      cnt_q   <= {`MCA_COUNT_WIDTH{1'b0}};
    end
    else
    begin
      case (state_q)
        mca_ctrl_pkg::timer_idle:
        begin
          if (acq_start)
          begin
            cnt_q <= acq_time;
            // a zero length gives no window, only the done pulse.
            if (acq_time == {`MCA_COUNT_WIDTH{1'b0}})
              state_q <= mca_ctrl_pkg::timer_done;
            else
              state_q <= mca_ctrl_pkg::timer_run;
          end
        end
        mca_ctrl_pkg::timer_run:
        begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == mca_data_pkg::count_t'(1))
          begin
            state_q <= mca_ctrl_pkg::timer_done;
          end
        end
        default:
        begin
          state_q <= mca_ctrl_pkg::timer_idle;
        end
      endcase
    end
  end

  assign counting_window = (state_q == mca_ctrl_pkg::timer_run);
  assign acq_busy        = counting_window;
  assign acq_done        = (state_q == mca_ctrl_pkg::timer_done);

endmodule

`default_nettype wire

// File: logic/mca_top.sv
`default_nettype none

`include "mca_params.svh"

module mca_top
(
  input  wire                      aclk,
  input  wire                      aresetn,

  input  mca_data_pkg::sample_t    sample_data,
  input  wire                      sample_valid,

  input  mca_data_pkg::delay_t     cfg_delay,
  input  mca_data_pkg::height_t    cfg_min_cut,
  input  mca_data_pkg::height_t    cfg_max_cut,

  input  wire                      acq_start,
  input  mca_data_pkg::count_t     acq_time,
  output logic                     acq_busy,
  output logic                     acq_done,

  input  wire                      clear_start,
  output logic                     clear_busy,

  input  mca_data_pkg::bin_addr_t  rd_addr,
  output mca_data_pkg::count_t     rd_data
);

  mca_data_pkg::height_t height_data;
  logic                  height_valid;
  logic                  height_ready;
  logic                  counting_window;

  pulse_height_analyzer u_analyzer (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .sample_data  (sample_data),
    .sample_valid (sample_valid),
    .cfg_delay    (cfg_delay),
    .cfg_min_cut  (cfg_min_cut),
    .cfg_max_cut  (cfg_max_cut),
    .height_ready (height_ready),
    .height_data  (height_data),
    .height_valid (height_valid)
  );

  acquisition_timer u_timer (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .acq_start       (acq_start),
    .acq_time        (acq_time),
    .counting_window (counting_window),
    .acq_busy        (acq_busy),
    .acq_done        (acq_done)
  );

  spectrum_histogram u_histogram (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .height_data     (height_data),
    .height_valid    (height_valid),
    .height_ready    (height_ready),
    .counting_window (counting_window),
    .clear_start     (clear_start),
    .clear_busy      (clear_busy),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

endmodule

`default_nettype wire

// File: sim/mca_assertions.sv
`default_nettype none

module mca_assertions
(
  input wire                   aclk,
  input wire                   aresetn,
  input wire                   acq_start,
  input mca_data_pkg::count_t  acq_time,
  input wire                   acq_busy,
  input wire                   acq_done,
  input wire                   clear_busy,
  input wire                   height_valid,
  input wire                   height_ready,
  input wire                   counting_window
);

  int   clear_cycles;
  int   busy_cycles;
  logic bin_take;

  // a height accepted inside the window starts a read-modify-write.
  assign bin_take = height_valid && height_ready && counting_window;

  always @(posedge aclk)
  begin
    if (!aresetn)
      clear_cycles <= 0;
    else if (clear_busy)
      clear_cycles <= clear_cycles + 1;
    else
      clear_cycles <= 0;
  end

  always @(posedge aclk)
  begin
    if (!aresetn)
      busy_cycles <= 0;
    else if (acq_busy)
      busy_cycles <= busy_cycles + 1;
    else
      busy_cycles <= 0;
  end

  a_busy_start: assert property (@(posedge aclk) disable iff (!aresetn)
    $rose(acq_busy) |-> $past(acq_start)) else $error("acq_busy rose without acq_start");

  a_busy_len: assert property (@(posedge aclk) disable iff (!aresetn)
    $fell(acq_busy) |-> busy_cycles == int'(acq_time))
    else $error("acq_busy length differs from acq_time");

  a_done_after_busy: assert property (@(posedge aclk) disable iff (!aresetn)
    $fell(acq_busy) |-> acq_done) else $error("acq_done missing after window");

  a_done_single: assert property (@(posedge aclk) disable iff (!aresetn)
    acq_done |=> !acq_done) else $error("acq_done longer than one cycle");

  a_clear_len: assert property (@(posedge aclk) disable iff (!aresetn)
    $fell(clear_busy) |-> clear_cycles == 256) else $error("clear sweep length wrong");

  a_rmw_stall: assert property (@(posedge aclk) disable iff (!aresetn)
    ($past(bin_take) || $past(bin_take, 2)) |-> !height_ready)
    else $error("height_ready high during a bin update");

endmodule

bind acquisition_timer mca_assertions u_timer_asrt (
  .aclk            (aclk),
  .aresetn         (aresetn),
  .acq_start       (acq_start),
  .acq_time        (acq_time),
  .acq_busy        (acq_busy),
  .acq_done        (acq_done),
  .clear_busy      (1'b0),
  .height_valid    (1'b0),
  .height_ready    (1'b0),
  .counting_window (1'b0)
);

bind spectrum_histogram mca_assertions u_hist_asrt (
  .aclk            (aclk),
  .aresetn         (aresetn),
  .acq_start       (1'b0),
  .acq_time        ('0),
  .acq_busy        (1'b0),
  .acq_done        (1'b0),
  .clear_busy      (clear_busy),
  .height_valid    (height_valid),
  .height_ready    (height_ready),
  .counting_window (counting_window)
);

`default_nettype wire

// File: sim/mca_checker.sv
`default_nettype none

`include "mca_params.svh"

module mca_checker
(
  input wire                          aclk,
  input wire                          aresetn,
  input wire [`MCA_SAMPLE_WIDTH-1:0]  sample_data,
  input wire                          sample_valid,
  input wire [`MCA_DELAY_WIDTH-1:0]   cfg_delay,
  input wire [`MCA_SAMPLE_WIDTH-1:0]  cfg_min_cut,
  input wire [`MCA_SAMPLE_WIDTH-1:0]  cfg_max_cut,
  input wire [`MCA_COUNT_WIDTH-1:0]   acq_time,
  input wire                          acq_busy,
  input wire                          acq_done,
  input wire                          clear_start,
  input wire                          clear_busy,
  input wire                          rd_check,
  input wire [`MCA_BIN_BITS-1:0]      rd_addr,
  input wire [`MCA_COUNT_WIDTH-1:0]   rd_data
);

  logic [`MCA_COUNT_WIDTH-1:0]  exp_bins [0:(1<<`MCA_BIN_BITS)-1];
  logic [`MCA_SAMPLE_WIDTH-1:0] s0, s1, min_v;
  logic [`MCA_DELAY_WIDTH-1:0]  cnt;
  logic                         rise, armed, win, busy_q, done_q, chk_q, clr_q;
  logic [`MCA_BIN_BITS-1:0]     addr_q;
  int                           busy_len;
  int                           mismatches;
  int                           other_errs;
  int                           done_pulses;

  always @(posedge aclk)
  begin
    logic                         r;
    logic                         in_del;
    logic [`MCA_SAMPLE_WIDTH-1:0] h;
    if (!aresetn)
    begin
      s0 = '0;
      s1 = '0;
      min_v = '0;
      cnt = '0;
      rise = 1'b0;
      armed = 1'b0;
      win = 1'b0;
      busy_q = 1'b0;
      done_q = 1'b0;
      chk_q = 1'b0;
      clr_q = 1'b0;
      busy_len = 0;
    end
    else
    begin
      // window opens on busy rising, closes when done falls.
      if (acq_busy && !busy_q)
        win = 1'b1;
      if (done_q && !acq_done)
        win = 1'b0;
      if (acq_busy)
        busy_len = busy_len + 1;
      if (busy_q && !acq_busy)
      begin
        if (busy_len != int'(acq_time))
        begin
          $display("acq_busy lasted %0d cycles instead of %0d", busy_len, acq_time);
          other_errs++;
        end
        busy_len = 0;
      end
      if (acq_done)
        done_pulses++;
      if (clr_q && !clear_busy)
      begin
        $display("clear_busy did not rise after clear_start");
        other_errs++;
      end
      if (clear_start)
        foreach (exp_bins[i])
          exp_bins[i] = '0;
      if (sample_valid)
      begin
        r = s1 < sample_data;
        in_del = cnt < cfg_delay;
        h = s0 - min_v;
        if (in_del)
          cnt = cnt + 1'b1;
        if (armed && rise && !r && h > cfg_min_cut)
        begin
          armed = 1'b0;
          cnt = '0;
          if (s0 < cfg_max_cut && win)
            exp_bins[h[`MCA_SAMPLE_WIDTH-1 -: `MCA_BIN_BITS]]++;
        end
        // a new minimum is taken from the samples before this one.
        if (!in_del && !rise && r)
        begin
          min_v = s1;
          armed = 1'b1;
        end
        s1 = s0;
        s0 = sample_data;
        rise = r;
      end
      if (chk_q && rd_data !== exp_bins[addr_q])
      begin
        $display("[FAIL] rd_data bin %h: got %h expected %h", addr_q, rd_data, exp_bins[addr_q]);
        mismatches++;
      end
      chk_q = rd_check;
      clr_q = clear_start;
      addr_q = rd_addr;
      busy_q = acq_busy;
      done_q = acq_done;
    end
  end

endmodule

`default_nettype wire

// File: sim/mca_tb.sv
`default_nettype none

module mca_tb;

  localparam int N_ROWS = 8;

  logic                     aclk;
  logic                     aresetn;
  mca_data_pkg::sample_t    sample_data;
  logic                     sample_valid;
  mca_data_pkg::delay_t     cfg_delay;
  mca_data_pkg::height_t    cfg_min_cut;
  mca_data_pkg::height_t    cfg_max_cut;
  logic                     acq_start;
  mca_data_pkg::count_t     acq_time;
  logic                     acq_busy;
  logic                     acq_done;
  logic                     clear_start;
  logic                     clear_busy;
  logic                     rd_check;
  mca_data_pkg::bin_addr_t  rd_addr;
  mca_data_pkg::count_t     rd_data;

  // baseline, peak, flat gap before the ramp, window flag, random gaps.
  int row_base [N_ROWS] = '{1000, 1000, 1000, 1000, 1000, 800, 800, 800};
  int row_peak [N_ROWS] = '{5736, 5736, 1200, 63488, 13288, 17184, 9504, 9504};
  int row_gap  [N_ROWS] = '{16, 16, 16, 16, 2, 16, 16, 16};
  int row_win  [N_ROWS] = '{1, 1, 1, 1, 1, 1, 0, 0};
  int row_rnd  [N_ROWS] = '{0, 1, 0, 0, 0, 1, 0, 1};

  int seed = 15;
  int cycles = 0;
  int limit = 0;
  int tb_errs = 0;

  mca_top UUT (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .sample_data  (sample_data),
    .sample_valid (sample_valid),
    .cfg_delay    (cfg_delay),
    .cfg_min_cut  (cfg_min_cut),
    .cfg_max_cut  (cfg_max_cut),
    .acq_start    (acq_start),
    .acq_time     (acq_time),
    .acq_busy     (acq_busy),
    .acq_done     (acq_done),
    .clear_start  (clear_start),
    .clear_busy   (clear_busy),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data)
  );

  mca_checker u_checker (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .sample_data  (sample_data),
    .sample_valid (sample_valid),
    .cfg_delay    (cfg_delay),
    .cfg_min_cut  (cfg_min_cut),
    .cfg_max_cut  (cfg_max_cut),
    .acq_time     (acq_time),
    .acq_busy     (acq_busy),
    .acq_done     (acq_done),
    .clear_start  (clear_start),
    .clear_busy   (clear_busy),
    .rd_check     (rd_check),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data)
  );

  initial
  begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  always @(posedge aclk)
  begin
    cycles++;
    if (limit != 0 && cycles > limit)
    begin
      $display("timeout: run exceeded %0d cycles", limit);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic tick();
    @(posedge aclk);
    #1;
  endtask

  task automatic send_sample(input int value, input int rnd);
    if (rnd != 0 && ($random(seed) & 1))
    begin
      sample_valid = 1'b0;
      tick();
    end
    sample_data  = mca_data_pkg::sample_t'(value);
    sample_valid = 1'b1;
    tick();
    sample_valid = 1'b0;
  endtask

  // flat gap, eight steps up, eight steps down.
  task automatic play_row(input int i);
    int st;
    st = (row_peak[i] - row_base[i]) / 8;
    for (int k = 0; k < row_gap[i]; k++)
      send_sample(row_base[i], row_rnd[i]);
    for (int k = 1; k <= 8; k++)
      send_sample(row_base[i] + k * st, row_rnd[i]);
    for (int k = 1; k <= 8; k++)
      send_sample(row_peak[i] - k * st, row_rnd[i]);
  endtask

  task automatic clear_bins();
    clear_start = 1'b1;
    tick();
    clear_start = 1'b0;
    while (clear_busy)
      tick();
  endtask

  task automatic read_all();
    for (int a = 0; a < 256; a++)
    begin
      rd_addr  = mca_data_pkg::bin_addr_t'(a);
      rd_check = 1'b1;
      tick();
    end
    rd_check = 1'b0;
    tick();
    tick();
  endtask

  initial
  begin
    int total;
    int win_total;
    total = 0;
    win_total = 0;
    for (int i = 0; i < N_ROWS; i++)
    begin
      total += row_gap[i] + 16;
      if (row_win[i] != 0)
        win_total += row_gap[i] + 16;
    end
    aresetn      = 1'b0;
    sample_data  = '0;
    sample_valid = 1'b0;
    cfg_delay    = mca_data_pkg::delay_t'(12);
    cfg_min_cut  = mca_data_pkg::height_t'(300);
    cfg_max_cut  = mca_data_pkg::height_t'(16'hf000);
    acq_start    = 1'b0;
    acq_time     = mca_data_pkg::count_t'(2 * win_total + 40);
    clear_start  = 1'b0;
    rd_check     = 1'b0;
    rd_addr      = '0;
    limit = 2 * total + int'(acq_time) + 5 * 256 + 100;
    repeat (3) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    tick();
    clear_bins();
    read_all();
    acq_start = 1'b1;
    tick();
    acq_start = 1'b0;
    for (int i = 0; i < N_ROWS; i++)
    begin
      // window rows come first, the rest wait for the window to close.
      if (row_win[i] == 0)
        while (acq_busy || acq_done)
          tick();
      play_row(i);
    end
    repeat (8) tick();
    read_all();
    // filled bins must read back as zero after a second sweep.
    clear_bins();
    read_all();
    if (u_checker.done_pulses != 1)
    begin
      $display("acq_done pulsed %0d times instead of once", u_checker.done_pulses);
      tb_errs++;
    end
    $display("errors: %0d mismatches, %0d other", u_checker.mismatches,
             u_checker.other_errs + tb_errs);
    if (u_checker.mismatches + u_checker.other_errs + tb_errs == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/mca_data_pkg.sv
logic/mca_ctrl_pkg.sv
logic/pulse_height_analyzer.sv
logic/spectrum_histogram.sv
logic/acquisition_timer.sv
logic/mca_top.sv
sim/mca_assertions.sv
sim/mca_checker.sv
sim/mca_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module mca_tb \
  --Mdir obj_dir -o mca_sim

./obj_dir/mca_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
if ! grep -q "Regression passed" sim.log; then
  exit 1
fi
exit 0
